// ==== Bender.yml ====
package:
  name: hw_sw_synch

sources:
  - files:
      - verilog/trn_pkg.sv
      - verilog/ring_pkg.sv
      - verilog/host_pointer_rcv.sv
      - verilog/ring_tracker.sv
      - verilog/irq_gen.sv
      - verilog/hw_sw_synch_top.sv
  - target: test
    files:
      - tb/hw_sw_synch_checker.sv
      - tb/tb_hw_sw_synch.sv

// ==== project.f ====
verilog/trn_pkg.sv
verilog/ring_pkg.sv
verilog/host_pointer_rcv.sv
verilog/ring_tracker.sv
verilog/irq_gen.sv
verilog/hw_sw_synch_top.sv
tb/hw_sw_synch_checker.sv
tb/tb_hw_sw_synch.sv

// ==== tb/hw_sw_synch_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module hw_sw_synch_checker #(
    parameter int ring_log2 = ring_pkg::ring_log2_dflt
) (
    input wire                        trn_clk,
    input wire                        reset,
    input wire  [ring_pkg::ptr_w-1:0] sw_pointer,
    input wire  [ring_pkg::ptr_w-1:0] hw_pointer,
    input wire  [ring_pkg::ptr_w-1:0] occupancy,
    input wire                        irq
);
    import ring_pkg::*;

    localparam logic [ptr_w-1:0] ring_mask = (ptr_w'(1) << ring_log2) - ptr_w'(1);

    int fail_count = 0;                              // failed assertion count

    a_irq_single: assert property (@(posedge trn_clk) disable iff (reset) irq |=> !irq)
        else begin
            $error("irq high on two consecutive cycles");
            fail_count = fail_count + 1;
        end

    // sw_pointer reaches the ring copy one cycle late
    a_occ_in_sync: assert property (@(posedge trn_clk) disable iff (reset)
        ((($past(sw_pointer) ^ hw_pointer) & ring_mask) == '0) |-> (occupancy == '0))
        else begin
            $error("occupancy not zero while pointers match");
            fail_count = fail_count + 1;
        end

    a_known: assert property (@(posedge trn_clk) disable iff (reset)
        !$isunknown({sw_pointer, hw_pointer, occupancy, irq}))
        else begin
            $error("unknown value on an output");
            fail_count = fail_count + 1;
        end

endmodule

bind hw_sw_synch_top hw_sw_synch_checker #(
    .ring_log2 (ring_log2)
) i_hw_sw_synch_checker (
    .trn_clk    (trn_clk),
    .reset      (reset),
    .sw_pointer (sw_pointer),
    .hw_pointer (hw_pointer),
    .occupancy  (occupancy),
    .irq        (irq)
);

`default_nettype wire

// ==== tb/synch_stim.txt ====
# name op | beat: sof eof dsc bar_hit_n data upd exp_sw | idle: cycles 0 0 0 0 irq_total 0
# frame: len 0 0 0 0 0 0 | all numbers hex
frame_a frame 100 0 0 0 0 0 0
wr32 beat 1 0 0 7b 40000002010000ff 0 0
wr32 beat 0 0 0 7b 0000100000d1bc9a 0 0
wr32 beat 0 1 0 7b 7856341200000000 1 123456789abcd100
frame_b frame 240 0 0 0 0 0 0
wr64 beat 1 0 0 7b 60000002010000ff 0 0
wr64 beat 0 0 0 7b 0000000100002000 0 0
wr64 beat 0 1 0 7b 4003000000000080 1 8000000000000340
bad_bar beat 1 0 0 7e 40000002010000ff 0 0
bad_bar beat 0 0 0 7e 0000100000050000 0 0
bad_bar beat 0 1 0 7e 0000000000000000 0 0
bad_off beat 1 0 0 7b 60000002010000ff 0 0
bad_off beat 0 0 0 7b 0000000100002008 0 0
bad_off beat 0 1 0 7b 0006000000000000 0 0
rd_tlp beat 1 0 0 7b 000000010100000f 0 0
rd_tlp beat 0 1 0 7b 0000100000000000 0 0
dsc beat 1 0 0 7b 40000002010000ff 0 0
dsc beat 0 0 0 7b 0000100000070000 0 0
dsc beat 0 1 1 7b 7856341200000000 0 0
quiet idle 4 0 0 0 0 0 0
frame_c frame e00 0 0 0 0 0 0
hold idle 2d 0 0 0 0 1 0
rearm beat 1 0 0 7b 40000002010000ff 0 0
rearm beat 0 0 0 7b 0000100000020000 0 0
rearm beat 0 1 0 7b 0000000000000000 1 200
rearm idle 6 0 0 0 0 2 0
frame_d frame c0 0 0 0 0 0 0
final idle 19 0 0 0 0 2 0

// ==== tb/tb_hw_sw_synch.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_hw_sw_synch;
    import ring_pkg::*;

    localparam int               irq_hold  = 20;    // longer than any TLP with stalls
    localparam logic [ptr_w-1:0] ring_mask = (ptr_w'(1) << ring_log2_dflt) - ptr_w'(1);

    logic             trn_clk;
    logic             reset;
    logic [63:0]      trn_rd;
    logic [7:0]       trn_rrem_n;
    logic             trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n, trn_rsrc_dsc_n, trn_rdst_rdy_n;
    logic [6:0]       trn_rbar_hit_n;
    logic             frame_done;
    logic [len_w-1:0] frame_len;
    wire  [ptr_w-1:0] sw_pointer, hw_pointer, occupancy;
    wire              irq;

    string       t_name [0:63];                      // stimulus table
    string       t_op [0:63];
    logic [63:0] t_arg [0:63][0:6];
    string       line, cur_name;
    integer      fd, cnt, n_lines, i;
    integer      seed = 97867;
    int          cycle_cnt = 0;
    int          cycle_limit;
    logic             ptr_beat;                      // beat carries the last pointer word
    logic [ptr_w-1:0] ptr_exp;                       // pointer value from the file
    logic [ptr_w-1:0] m_sw, m_hw, m_swr, m_occ, n_hw, n_swr;
    logic             m_valid, m_oos, m_upd, m_armed, irq_now;
    int               m_run, irq_seen;               // m_run counts earlier out of sync cycles

    hw_sw_synch_top #(
        .irq_holdoff (irq_hold)
    ) i_hw_sw_synch_top (
        .trn_clk        (trn_clk),
        .reset          (reset),
        .trn_rd         (trn_rd),
        .trn_rrem_n     (trn_rrem_n),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rsrc_dsc_n (trn_rsrc_dsc_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .trn_rdst_rdy_n (trn_rdst_rdy_n),
        .frame_done     (frame_done),
        .frame_len      (frame_len),
        .sw_pointer     (sw_pointer),
        .hw_pointer     (hw_pointer),
        .occupancy      (occupancy),
        .irq            (irq)
    );

    task automatic report_mismatch(input string test, input string sig,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("ERR %s %s expected %h actual %h", test, sig, exp, act);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic idle_bus();                       // nothing offered and no frame event
        trn_rsrc_rdy_n <= 1'b1;
        trn_rdst_rdy_n <= 1'b0;
        trn_rsof_n     <= 1'b1;
        trn_reof_n     <= 1'b1;
        trn_rsrc_dsc_n <= 1'b1;
        frame_done     <= 1'b0;
        ptr_beat       <= 1'b0;
    endtask

    task automatic drive_beat(input int idx);
        int n_stall;
        int k;
        n_stall = $unsigned($random(seed)) % 3;      // 0..2 wait cycles before the beat
        for (k = 0; k <= n_stall; k++) begin
            @(posedge trn_clk);
            idle_bus();
            trn_rsof_n     <= ~t_arg[idx][0][0];
            trn_reof_n     <= ~t_arg[idx][1][0];
            trn_rsrc_dsc_n <= ~t_arg[idx][2][0];
            trn_rbar_hit_n <= t_arg[idx][3][6:0];
            trn_rd         <= t_arg[idx][4];
            if (k < n_stall) begin
                if ($random(seed) & 1) begin
                    trn_rsrc_rdy_n <= 1'b1;          // source not ready
                end else begin
                    trn_rsrc_rdy_n <= 1'b0;
                    trn_rdst_rdy_n <= 1'b1;          // sink not ready
                end
            end else begin
                trn_rsrc_rdy_n <= 1'b0;              // beat taken on next edge
                ptr_beat       <= t_arg[idx][5][0];
                ptr_exp        <= t_arg[idx][6];
            end
        end
    endtask

    initial begin
        trn_clk = 1'b0;
        forever #4 trn_clk = ~trn_clk;
    end

    ////////////////////////////////////////////////////////////////////
    // reference model checked mid cycle
    ////////////////////////////////////////////////////////////////////
    always @(negedge trn_clk) begin
        if (reset !== 1'b0) begin
            m_sw    = '0;
            m_hw    = '0;
            m_swr   = '0;
            m_occ   = '0;
            m_valid = 1'b0;
            m_oos   = 1'b0;
            m_upd   = 1'b0;
            m_armed = 1'b1;
            m_run   = 0;
        end else begin
            irq_now = m_armed && m_oos && (m_run + 1 >= irq_hold);
            assert (sw_pointer === m_sw)
                else report_mismatch(cur_name, "sw_pointer", m_sw, sw_pointer);
            assert (hw_pointer === m_hw)
                else report_mismatch(cur_name, "hw_pointer", m_hw, hw_pointer);
            assert (occupancy === m_occ)
                else report_mismatch(cur_name, "occupancy", m_occ, occupancy);
            assert (irq === irq_now)
                else report_mismatch(cur_name, "irq", irq_now, irq);
            assert (i_hw_sw_synch_top.i_hw_sw_synch_checker.fail_count == 0)
                else report_failure("a bound checker assertion fired");
            if (irq) irq_seen++;
            n_hw  = frame_done ? ((m_hw + ptr_w'(frame_len)) & ring_mask) : m_hw;
            n_swr = m_valid ? (m_sw & ring_mask) : m_swr;        // ring copy lags one cycle
            m_run   = !m_oos ? 0 : ((m_run < irq_hold) ? m_run + 1 : m_run);
            m_armed = irq_now ? 1'b0 : (m_upd ? 1'b1 : m_armed);
            m_upd   = m_valid;
            m_hw    = n_hw;
            m_swr   = n_swr;
            m_occ   = (n_hw - n_swr) & ring_mask;
            m_oos   = (n_hw != n_swr);
            m_valid = !trn_rsrc_rdy_n && !trn_rdst_rdy_n && ptr_beat;
            if (m_valid) m_sw = ptr_exp;
        end
    end

    always @(posedge trn_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) report_failure("timeout, stimulus did not finish in time");
    end

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////
    initial begin
        reset          = 1'b1;
        trn_rd         = '0;
        trn_rrem_n     = 8'h00;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rsrc_dsc_n = 1'b1;
        trn_rbar_hit_n = 7'h7f;
        trn_rdst_rdy_n = 1'b0;
        frame_done     = 1'b0;
        frame_len      = '0;
        ptr_beat       = 1'b0;
        ptr_exp        = '0;
        irq_seen       = 0;
        n_lines        = 0;
        cur_name       = "reset";
        fd = $fopen("tb/synch_stim.txt", "r");
        if (fd == 0) report_failure("cannot open tb/synch_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h", t_name[n_lines], t_op[n_lines],
                              t_arg[n_lines][0], t_arg[n_lines][1], t_arg[n_lines][2],
                              t_arg[n_lines][3], t_arg[n_lines][4], t_arg[n_lines][5],
                              t_arg[n_lines][6]);
                if (cnt != 9) report_failure("malformed line in stimulus file");
                n_lines++;
            end
        end
        $fclose(fd);
        cycle_limit = 4 * n_lines + 200;
        repeat (10) @(posedge trn_clk);
        reset <= 1'b0;
        for (i = 0; i < n_lines; i++) begin
            cur_name = t_name[i];
            if (t_op[i] == "beat") begin
                drive_beat(i);
            end else if (t_op[i] == "frame") begin
                @(posedge trn_clk);
                idle_bus();
                frame_done <= 1'b1;                  // single cycle pulse
                frame_len  <= t_arg[i][0][len_w-1:0];
            end else if (t_op[i] == "idle") begin
                repeat (int'(t_arg[i][0])) begin
                    @(posedge trn_clk);
                    idle_bus();
                end
                assert (irq_seen == t_arg[i][5])
                    else report_mismatch(t_name[i], "irq count", t_arg[i][5], irq_seen);
            end else begin
                report_failure("unknown opcode in stimulus file");
            end
        end
        @(posedge trn_clk);
        if (i_hw_sw_synch_top.i_hw_sw_synch_checker.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/host_pointer_rcv.sv ====
`timescale 1ns/1ns
`default_nettype none

module host_pointer_rcv #(
    parameter int         bar_hit_idx = 2,
    parameter logic [5:0] reg_offset  = 6'd0
) (
    input  wire                            trn_clk,
    input  wire                            reset,

    input  wire  [trn_pkg::trn_data_w-1:0] trn_rd,
    input  wire                            trn_rsof_n,
    input  wire                            trn_reof_n,
    input  wire                            trn_rsrc_rdy_n,
    input  wire                            trn_rsrc_dsc_n,
    input  wire  [6:0]                     trn_rbar_hit_n,
    input  wire                            trn_rdst_rdy_n,

    output logic [ring_pkg::ptr_w-1:0]     sw_pointer,
    output logic                           sw_pointer_valid
);
    import trn_pkg::*;

    // one-hot states
    localparam logic [4:0] st_idle   = 5'b00001;
    localparam logic [4:0] st_hdr32  = 5'b00010;   // expect addr + data0
    localparam logic [4:0] st_hdr64  = 5'b00100;   // expect addr hi/lo
    localparam logic [4:0] st_data32 = 5'b01000;   // expect data1 in upper half
    localparam logic [4:0] st_data64 = 5'b10000;   // expect data0 + data1

    logic [4:0]  state;
    logic        beat_ok;
    logic        bar_ok;
    logic [6:0]  fmt_type;
    trn_beat1_u  beat1;
    logic        off32_hit;
    logic        off64_hit;
    logic [31:0] data0_q;                          // low pointer dword of a 3dw write

    // pcie byte order to little endian
    function automatic logic [31:0] swap_dw(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // beat decode
    ////////////////////////////////////////////////////////////////////
    assign beat_ok  = ~trn_rsrc_rdy_n & ~trn_rdst_rdy_n;   // observe only, never stall
    assign bar_ok   = ~trn_rbar_hit_n[bar_hit_idx];
    assign fmt_type = trn_rd[fmt_type_hi:fmt_type_lo];
    assign beat1    = trn_rd;                               // valid in hdr states only

    assign off32_hit = (beat1.mem32.addr[dw_off_hi:dw_off_lo] == reg_offset);
    assign off64_hit = (beat1.mem64.addr_lo[dw_off_hi:dw_off_lo] == reg_offset);

    ////////////////////////////////////////////////////////////////////
    // snoop fsm
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state            <= st_idle;
            sw_pointer       <= '0;
            sw_pointer_valid <= 1'b0;
        end else begin
            sw_pointer_valid <= 1'b0;                       // strobe default
            if (beat_ok) begin                              // stalls hold state
                if (!trn_rsrc_dsc_n) begin
                    state <= st_idle;                       // discontinued tlp
                end else begin
                    case (state)
                        st_idle: begin
                            if (!trn_rsof_n && trn_reof_n && bar_ok) begin
                                if (fmt_type == mem_wr32_fmt_type) begin
                                    state <= st_hdr32;
                                end else if (fmt_type == mem_wr64_fmt_type) begin
                                    state <= st_hdr64;
                                end
                            end
                        end
                        st_hdr32: begin
                            if (trn_reof_n && off32_hit) begin
                                state <= st_data32;
                            end else begin
                                state <= st_idle;           // other reg or short tlp
                            end
                        end
                        st_hdr64: begin
                            if (trn_reof_n && off64_hit) begin
                                state <= st_data64;
                            end else begin
                                state <= st_idle;
                            end
                        end
                        st_data32: begin
                            sw_pointer       <= {swap_dw(trn_rd[63:32]), swap_dw(data0_q)};
                            sw_pointer_valid <= 1'b1;
                            state            <= st_idle;
                        end
                        st_data64: begin
                            sw_pointer       <= {swap_dw(trn_rd[31:0]), swap_dw(trn_rd[63:32])};
                            sw_pointer_valid <= 1'b1;
                            state            <= st_idle;
                        end
                        default: begin
                            state <= st_idle;               // illegal code
                        end
                    endcase
                end
            end
        end
    end

    // first payload dword rides in beat 1 of a 3dw write
    always_ff @(posedge trn_clk) begin
        if (beat_ok && (state == st_hdr32)) begin
            data0_q <= beat1.mem32.data0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hw_sw_synch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module hw_sw_synch_top #(
    parameter int         bar_hit_idx = 2,
    parameter logic [5:0] reg_offset  = 6'd0,
    parameter int         ring_log2   = ring_pkg::ring_log2_dflt,
    parameter int         irq_holdoff = ring_pkg::irq_holdoff_dflt
) (
    input  wire                            trn_clk,
    input  wire                            reset,

    // trn receive, observed only
    input  wire  [trn_pkg::trn_data_w-1:0] trn_rd,
    input  wire  [7:0]                     trn_rrem_n,     // pointer beats are always full
    input  wire                            trn_rsof_n,
    input  wire                            trn_reof_n,
    input  wire                            trn_rsrc_rdy_n,
    input  wire                            trn_rsrc_dsc_n,
    input  wire  [6:0]                     trn_rbar_hit_n,
    input  wire                            trn_rdst_rdy_n,

    // dma side
    input  wire                            frame_done,
    input  wire  [ring_pkg::len_w-1:0]     frame_len,

    output wire  [ring_pkg::ptr_w-1:0]     sw_pointer,
    output wire  [ring_pkg::ptr_w-1:0]     hw_pointer,
    output wire  [ring_pkg::ptr_w-1:0]     occupancy,
    output wire                            irq
);
    wire sw_pointer_valid;
    wire out_of_sync;
    wire sw_update;

    ////////////////////////////////////////////////////////////////////
    // producer, buffer, consumer
    ////////////////////////////////////////////////////////////////////
    host_pointer_rcv #(
        .bar_hit_idx (bar_hit_idx),
        .reg_offset  (reg_offset)
    ) i_host_pointer_rcv (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .trn_rd           (trn_rd),
        .trn_rsof_n       (trn_rsof_n),
        .trn_reof_n       (trn_reof_n),
        .trn_rsrc_rdy_n   (trn_rsrc_rdy_n),
        .trn_rsrc_dsc_n   (trn_rsrc_dsc_n),
        .trn_rbar_hit_n   (trn_rbar_hit_n),
        .trn_rdst_rdy_n   (trn_rdst_rdy_n),
        .sw_pointer       (sw_pointer),
        .sw_pointer_valid (sw_pointer_valid)
    );

    ring_tracker #(
        .ring_log2 (ring_log2)
    ) i_ring_tracker (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .sw_pointer       (sw_pointer),
        .sw_pointer_valid (sw_pointer_valid),
        .frame_done       (frame_done),
        .frame_len        (frame_len),
        .hw_pointer       (hw_pointer),
        .occupancy        (occupancy),
        .out_of_sync      (out_of_sync),
        .sw_update        (sw_update)
    );

    irq_gen #(
        .irq_holdoff (irq_holdoff)
    ) i_irq_gen (
        .trn_clk     (trn_clk),
        .reset       (reset),
        .out_of_sync (out_of_sync),
        .sw_update   (sw_update),
        .irq         (irq)
    );

endmodule

`default_nettype wire

// ==== verilog/irq_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_gen #(
    parameter int irq_holdoff = ring_pkg::irq_holdoff_dflt
) (
    input  wire  trn_clk,
    input  wire  reset,

    input  wire  out_of_sync,
    input  wire  sw_update,

    output logic irq
);
    localparam int             cnt_w  = $clog2(irq_holdoff + 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(irq_holdoff - 1);  // holdoff minus this cycle

    logic [cnt_w-1:0] sync_cnt;                     // prior consecutive out of sync cycles
    logic             armed;
    logic             holdoff_met;

    ////////////////////////////////////////////////////////////////////
    // holdoff counter
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            sync_cnt <= '0;
        end else if (!out_of_sync) begin
            sync_cnt <= '0;                         // back in sync
        end else if (sync_cnt != cnt_max) begin
            sync_cnt <= sync_cnt + cnt_w'(1);       // saturate at cnt_max
        end
    end

    // current cycle is the irq_holdoff-th in a row
    assign holdoff_met = out_of_sync && (sync_cnt == cnt_max);

    ////////////////////////////////////////////////////////////////////
    // arm flag
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            armed <= 1'b1;                          // armed out of reset
        end else if (irq) begin
            armed <= 1'b0;                          // one shot, wins over re-arm
        end else if (sw_update) begin
            armed <= 1'b1;                          // sw moved, allow next irq
        end
    end

    assign irq = armed && holdoff_met;              // single cycle, flag drops next edge

endmodule

`default_nettype wire

// ==== verilog/ring_pkg.sv ====
`default_nettype none

package ring_pkg;

    ////////////////////////////////////////////////////////////////////
    // ring side widths
    ////////////////////////////////////////////////////////////////////
    localparam int ptr_w = 64;              // sw and hw pointer width
    localparam int len_w = 16;              // frame length field

    ////////////////////////////////////////////////////////////////////
    // defaults used by the top level
    ////////////////////////////////////////////////////////////////////
    localparam int ring_log2_dflt   = 12;   // 4 KiB ring
    localparam int irq_holdoff_dflt = 16;   // cycles out of sync before irq

endpackage

`default_nettype wire

// ==== verilog/ring_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ring_tracker #(
    parameter int ring_log2 = ring_pkg::ring_log2_dflt
) (
    input  wire                        trn_clk,
    input  wire                        reset,

    input  wire  [ring_pkg::ptr_w-1:0] sw_pointer,
    input  wire                        sw_pointer_valid,
    input  wire                        frame_done,
    input  wire  [ring_pkg::len_w-1:0] frame_len,

    output logic [ring_pkg::ptr_w-1:0] hw_pointer,
    output logic [ring_pkg::ptr_w-1:0] occupancy,
    output logic                       out_of_sync,
    output logic                       sw_update
);
    import ring_pkg::*;

    localparam logic [ptr_w-1:0] ring_mask = (ptr_w'(1) << ring_log2) - ptr_w'(1);

    logic [ptr_w-1:0] sw_ring;                      // registered sw copy, modulo ring
    logic [ptr_w-1:0] hw_next;
    logic [ptr_w-1:0] sw_next;

    ////////////////////////////////////////////////////////////////////
    // next pointer values
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        hw_next = hw_pointer;
        sw_next = sw_ring;
        if (frame_done) begin
            hw_next = (hw_pointer + ptr_w'(frame_len)) & ring_mask;  // wrap at ring end
        end
        if (sw_pointer_valid) begin
            sw_next = sw_pointer & ring_mask;
        end
    end

    // occupancy and sync level follow the pointers in the same cycle
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            hw_pointer  <= '0;
            sw_ring     <= '0;
            occupancy   <= '0;
            out_of_sync <= 1'b0;
            sw_update   <= 1'b0;
        end else begin
            hw_pointer  <= hw_next;
            sw_ring     <= sw_next;
            occupancy   <= (hw_next - sw_next) & ring_mask;
            out_of_sync <= (hw_next != sw_next);
            sw_update   <= sw_pointer_valid;        // re-arm pulse for irq_gen
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trn_pkg.sv ====
`default_nettype none

package trn_pkg;

    ////////////////////////////////////////////////////////////////////
    // trn receive beat layout
    ////////////////////////////////////////////////////////////////////
    localparam int trn_data_w = 64;         // trn_rd width

    localparam int fmt_type_hi = 62;        // fmt/type in beat 0
    localparam int fmt_type_lo = 56;
    localparam int dw_off_hi   = 7;         // dword offset inside an address dword
    localparam int dw_off_lo   = 2;

    localparam logic [6:0] mem_wr32_fmt_type = 7'b10_00000; // 3dw write with data
    localparam logic [6:0] mem_wr64_fmt_type = 7'b11_00000; // 4dw write with data

    // second header beat of a 3dw write
    typedef struct packed {
        logic [31:0] addr;                  // address dword
        logic [31:0] data0;                 // first payload dword
    } beat1_mem32_t;

    // second header beat of a 4dw write
    typedef struct packed {
        logic [31:0] addr_hi;               // address bits 63:32
        logic [31:0] addr_lo;               // address bits 31:0
    } beat1_mem64_t;

    typedef union packed {
        beat1_mem32_t mem32;
        beat1_mem64_t mem64;
    } trn_beat1_u;

endpackage

`default_nettype wire
